/* Makefile */
TOP = dcache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f compile.f -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

/* compile.f */
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_hit_counter.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

/* dv/dcache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model import dcache_pkg::*; #(
	parameter int WORDS = 4096,
	parameter logic [31:0] SEED = 32'h1160
) (
	input logic CLK,
	input logic nRST,
	input logic wait_en,
	input logic mem_ren,
	input logic mem_wen,
	input addr_t mem_addr,
	input word_t mem_store,
	output word_t mem_load,
	output logic mem_wait
);

	localparam int AW = $clog2(WORDS);

	word_t mem [WORDS];
	logic [31:0] lcg;
	logic [1:0] wait_cnt;
	logic [AW-1:0] idx;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// initial contents mix the full byte address
	function automatic word_t fill_word(input addr_t addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
	endfunction

	assign idx = mem_addr[AW+1:2];
	assign mem_load = mem[idx];
	assign mem_wait = (mem_ren || mem_wen) && (wait_cnt != 2'd0);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lcg <= SEED;
			wait_cnt <= 2'd0;
			for (int i = 0; i < WORDS; i++) begin
				mem[i] <= fill_word(addr_t'(i) << 2);
			end
		end else if (mem_ren || mem_wen) begin
			if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else begin
				// transfer done, draw the stall length of the next one
				if (mem_wen) begin
					mem[idx] <= mem_store;
				end
				lcg <= lcg_next(lcg);
				wait_cnt <= wait_en ? lcg[17:16] : 2'd0;
			end
		end
	end

endmodule

`default_nettype wire

/* dv/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

	localparam int SETS = 8;
	localparam int MEM_WORDS = 4096;
	localparam int TIMEOUT = 200;
	localparam addr_t HIT_CNT_ADDR = 32'h3100;

	logic CLK;
	logic nRST;
	logic dmem_ren;
	logic dmem_wen;
	addr_t dmem_addr;
	word_t dmem_store;
	logic halt;
	logic dhit;
	word_t dmem_load;
	logic flushed;
	logic mem_ren;
	logic mem_wen;
	addr_t mem_addr;
	word_t mem_store;
	word_t mem_load;
	logic mem_wait;
	logic wait_en;

	// reference model of the metadata per set and way, the data the cpu sees and memory
	logic m_valid [SETS][WAYS];
	logic m_dirty [SETS][WAYS];
	logic [25:0] m_tag [SETS][WAYS];
	logic m_lru [SETS];
	word_t arch [MEM_WORDS];
	word_t phys [MEM_WORDS];
	word_t hit_total;
	int errors;
	int checks;

	dcache #(.SETS(SETS), .HIT_CNT_ADDR(HIT_CNT_ADDR)) u_dcache (.*);

	dcache_mem_model #(.WORDS(MEM_WORDS)) u_mem (.*);

	always #5 CLK = ~CLK;

	function automatic word_t init_word(input addr_t addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
	endfunction

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string msg);
		errors++;
		$display("timeout at %0t: %s", $time, msg);
	endtask

	task automatic reset_model();
		for (int i = 0; i < MEM_WORDS; i++) begin
			arch[i] = init_word(addr_t'(i) << 2);
			phys[i] = arch[i];
		end
		for (int s = 0; s < SETS; s++) begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w] = '0;
			end
		end
		hit_total = '0;
	endtask

	task automatic write_back_block(input logic [2:0] set, input logic way);
		addr_t base;
		base = {m_tag[set][way], set, 3'b000};
		phys[{base[13:3], 1'b0}] = arch[{base[13:3], 1'b0}];
		phys[{base[13:3], 1'b1}] = arch[{base[13:3], 1'b1}];
	endtask

	// lru bit names the next victim and the hit that ends a miss is not counted
	task automatic predict_access(input addr_t addr, input logic write, input word_t data,
		output logic exp_hit);
		logic [2:0] set;
		logic [25:0] tag;
		logic way;
		set = addr[5:3];
		tag = addr[31:6];
		exp_hit = 1'b0;
		way = m_lru[set];
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[set][w] && m_tag[set][w] == tag) begin
				exp_hit = 1'b1;
				way = w[0];
			end
		end
		if (exp_hit) begin
			hit_total = hit_total + 32'd1;
		end else begin
			if (m_dirty[set][way]) begin
				write_back_block(set, way);
			end
			m_valid[set][way] = 1'b1;
			m_tag[set][way] = tag;
			m_dirty[set][way] = 1'b0;
		end
		m_lru[set] = ~way;
		if (write) begin
			m_dirty[set][way] = 1'b1;
			arch[addr[13:2]] = data;
		end
	endtask

	task automatic flush_model();
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				if (m_dirty[s][w]) begin
					write_back_block(s[2:0], w[0]);
				end
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		end
		phys[HIT_CNT_ADDR[13:2]] = hit_total;
	endtask

	task automatic check_mem_word(input addr_t addr);
		checks++;
		if (u_mem.mem[addr[13:2]] !== phys[addr[13:2]]) begin
			errors++;
			$display("mismatch at %0t: memory word 0x%08h holds 0x%08h, expected 0x%08h",
				$time, addr, u_mem.mem[addr[13:2]], phys[addr[13:2]]);
		end
	endtask

	// one request held until dhit where memory strobes seen on the way mark a miss
	task automatic access(input addr_t addr, input logic write, input word_t data);
		logic exp_hit;
		logic saw_mem;
		logic served;
		word_t exp_data;
		word_t got;
		int cnt;
		exp_data = arch[addr[13:2]];
		predict_access(addr, write, data, exp_hit);
		@(negedge CLK);
		dmem_addr = addr;
		dmem_ren = !write;
		dmem_wen = write;
		dmem_store = data;
		saw_mem = 1'b0;
		cnt = 0;
		@(negedge CLK);
		while (!dhit && cnt < TIMEOUT) begin
			if (mem_ren || mem_wen) begin
				saw_mem = 1'b1;
			end
			@(negedge CLK);
			cnt++;
		end
		served = dhit;
		got = dmem_load;
		@(negedge CLK);
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		if (!served) begin
			report_timeout($sformatf("dhit never rose for address 0x%08h", addr));
		end else begin
			checks++;
			if (!write && got !== exp_data) begin
				errors++;
				$display("mismatch at %0t: read 0x%08h returned 0x%08h, expected 0x%08h",
					$time, addr, got, exp_data);
			end
			if (saw_mem == exp_hit) begin
				errors++;
				$display("mismatch at %0t: access to 0x%08h served as %s, expected %s",
					$time, addr, saw_mem ? "miss" : "hit", exp_hit ? "hit" : "miss");
			end
		end
	endtask

	task automatic read_miss_then_hit(input addr_t base);
		access(base + 32'h10, 1'b0, '0);
		access(base + 32'h14, 1'b0, '0);
	endtask

	task automatic write_hit_then_read(input addr_t base);
		access(base + 32'h14, 1'b1, {16'hbeef, base[15:0] + 16'h14});
		access(base + 32'h14, 1'b0, '0);
		check_mem_word(base + 32'h14);
	endtask

	// three tags in set 2 so the dirty block goes out and comes back
	task automatic evict_lru_way(input addr_t base);
		access(base + 32'h50, 1'b0, '0);
		access(base + 32'h90, 1'b1, {16'hcafe, base[15:0] + 16'h90});
		check_mem_word(base + 32'h10);
		check_mem_word(base + 32'h14);
		access(base + 32'h14, 1'b0, '0);
	endtask

	task automatic halt_and_flush();
		int cnt;
		@(negedge CLK);
		halt = 1'b1;
		flush_model();
		cnt = 0;
		while (!flushed && cnt < 4 * TIMEOUT) begin
			@(negedge CLK);
			cnt++;
		end
		if (!flushed) begin
			report_timeout("flushed never rose after halt");
		end else begin
			repeat (3) @(negedge CLK);
			checks++;
			if (!flushed) begin
				errors++;
				$display("flushed fell again before reset at %0t", $time);
			end
			checks++;
			if (u_mem.mem[HIT_CNT_ADDR[13:2]] !== hit_total) begin
				errors++;
				$display("mismatch at %0t: stored hit count %0d, expected %0d",
					$time, u_mem.mem[HIT_CNT_ADDR[13:2]], hit_total);
			end
			for (int i = 0; i < MEM_WORDS; i++) begin
				check_mem_word(addr_t'(i) << 2);
			end
		end
	endtask

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		halt = 1'b0;
		wait_en = 1'b0;
		errors = 0;
		checks = 0;
		reset_model();
		repeat (10) @(negedge CLK);
		nRST = 1'b1;
		read_miss_then_hit(32'h0);
		write_hit_then_read(32'h0);
		evict_lru_way(32'h0);
		// same sequence in a fresh region with memory stalls
		wait_en = 1'b1;
		read_miss_then_hit(32'h1000);
		write_hit_then_read(32'h1000);
		evict_lru_way(32'h1000);
		halt_and_flush();
		finish_run();
	end

endmodule

`default_nettype wire

/* verilog/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache import dcache_pkg::*; #(
	parameter int SETS = 8,
	parameter addr_t HIT_CNT_ADDR = 32'h3100
) (
	input logic CLK,
	input logic nRST,
	input logic dmem_ren,
	input logic dmem_wen,
	input addr_t dmem_addr,
	input word_t dmem_store,
	input logic halt,
	output logic dhit,
	output word_t dmem_load,
	output logic flushed,
	output logic mem_ren,
	output logic mem_wen,
	output addr_t mem_addr,
	output word_t mem_store,
	input word_t mem_load,
	input logic mem_wait
);

	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = 32 - IDX_W - BLK_OFF_W - BYTE_OFF_W;

	addr_t lookup_addr;
	logic [IDX_W-1:0] set_idx;
	logic way;
	logic [BLK_OFF_W-1:0] word_off;
	logic data_we;
	word_t data_wdata;
	word_t rdata;
	logic tag_we;
	logic valid_in;
	logic dirty_in;
	logic [TAG_W-1:0] tag_in;
	logic lru_we;
	logic lru_in;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic [TAG_W-1:0] victim_tag;
	logic victim_dirty;
	logic entry_dirty;
	logic count_en;
	word_t hit_count;

	dcache_ctrl #(.SETS(SETS), .HIT_CNT_ADDR(HIT_CNT_ADDR)) u_ctrl (.*);

	dcache_tag_array #(.SETS(SETS)) u_tags (.*);

	dcache_data_array #(.SETS(SETS)) u_data (
		.CLK(CLK),
		.set_idx(set_idx),
		.way(way),
		.word_off(word_off),
		.we(data_we),
		.wdata(data_wdata),
		.rdata(rdata)
	);

	dcache_hit_counter u_hits (
		.CLK(CLK),
		.nRST(nRST),
		.count_en(count_en),
		.hit_count(hit_count)
	);

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
	parameter int SETS = 8,
	parameter addr_t HIT_CNT_ADDR = 32'h3100,
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = 32 - IDX_W - BLK_OFF_W - BYTE_OFF_W
) (
	input logic CLK,
	input logic nRST,
	input logic dmem_ren,
	input logic dmem_wen,
	input addr_t dmem_addr,
	input word_t dmem_store,
	input logic halt,
	output logic dhit,
	output word_t dmem_load,
	output logic flushed,
	output logic mem_ren,
	output logic mem_wen,
	output addr_t mem_addr,
	output word_t mem_store,
	input word_t mem_load,
	input logic mem_wait,
	output addr_t lookup_addr,
	output logic [IDX_W-1:0] set_idx,
	output logic way,
	output logic [BLK_OFF_W-1:0] word_off,
	output logic data_we,
	output word_t data_wdata,
	input word_t rdata,
	output logic tag_we,
	output logic valid_in,
	output logic dirty_in,
	output logic [TAG_W-1:0] tag_in,
	output logic lru_we,
	output logic lru_in,
	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input logic [TAG_W-1:0] victim_tag,
	input logic victim_dirty,
	input logic entry_dirty,
	input word_t hit_count,
	output logic count_en
);

	localparam int IDX_LSB = BLK_OFF_W + BYTE_OFF_W;
	// flush counter holds set, pass within the set and word
	localparam int FL_W = IDX_W + 1 + BLK_OFF_W;

	dcache_state_t state, next_state;
	addr_t addr_q;
	logic req_q;
	logic filled_q;
	logic [BLK_OFF_W-1:0] word_cnt;
	logic [FL_W-1:0] flush_cnt;

	logic req;
	logic [TAG_W-1:0] req_tag;
	logic [IDX_W-1:0] req_idx;
	logic [BLK_OFF_W-1:0] req_off;
	logic [IDX_W-1:0] fl_set;
	logic [BLK_OFF_W-1:0] fl_word;
	logic word_last;
	logic fl_last_entry;
	logic entry_end;

	assign req = dmem_ren | dmem_wen;
	assign req_tag = addr_q[31 -: TAG_W];
	assign req_idx = addr_q[IDX_LSB +: IDX_W];
	assign req_off = addr_q[BYTE_OFF_W +: BLK_OFF_W];
	assign fl_set = flush_cnt[FL_W-1 -: IDX_W];
	assign fl_word = flush_cnt[BLK_OFF_W-1:0];
	assign word_last = (word_cnt == BLK_OFF_W'(WORDS_PER_BLK - 1));
	assign fl_last_entry = &flush_cnt[FL_W-1:BLK_OFF_W];
	// clean entries end at once, dirty ones after their last word is taken
	assign entry_end = (state == FLUSH) && (!entry_dirty ||
		((fl_word == BLK_OFF_W'(WORDS_PER_BLK - 1)) && !mem_wait));

	// req_q marks that addr_q holds the current request
	assign dhit = (state == IDLE) && req_q && req && hit;
	// the hit that ends a miss is not counted
	assign count_en = dhit && !filled_q;
	assign flushed = (state == DONE);
	assign dmem_load = rdata;

	// during the flush the lookup set follows the flush counter, and since
	// each entry is taken through the LRU way the victim outputs describe it
	assign lookup_addr = (state == FLUSH) ? (addr_t'(fl_set) << IDX_LSB) : addr_q;

	always_ff @(posedge CLK) begin
		if (state == IDLE) begin
			addr_q <= dmem_addr;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			req_q <= 1'b0;
			filled_q <= 1'b0;
			word_cnt <= '0;
			flush_cnt <= '0;
		end else begin
			state <= next_state;
			case (state)
				IDLE: begin
					req_q <= req && !dhit;
					word_cnt <= '0;
					flush_cnt <= '0;
					if (dhit) begin
						filled_q <= 1'b0;
					end
				end
				WRITE_BACK, ALLOCATE: begin
					if (!mem_wait) begin
						word_cnt <= word_cnt + 1'b1;
					end
					if (state == ALLOCATE && !mem_wait && word_last) begin
						filled_q <= 1'b1;
					end
				end
				FLUSH: begin
					if (entry_end) begin
						flush_cnt <= {flush_cnt[FL_W-1:BLK_OFF_W] + 1'b1, {BLK_OFF_W{1'b0}}};
					end else if (!mem_wait) begin
						flush_cnt <= flush_cnt + 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (halt) begin
					next_state = FLUSH;
				end else if (req_q && req && !hit) begin
					next_state = victim_dirty ? WRITE_BACK : ALLOCATE;
				end
			end
			WRITE_BACK: begin
				if (!mem_wait && word_last) begin
					next_state = ALLOCATE;
				end
			end
			ALLOCATE: begin
				if (!mem_wait && word_last) begin
					next_state = IDLE;
				end
			end
			FLUSH: begin
				if (entry_end && fl_last_entry) begin
					next_state = FLUSH_COUNT;
				end
			end
			FLUSH_COUNT: begin
				if (!mem_wait) begin
					next_state = DONE;
				end
			end
			default: begin
				next_state = DONE;
			end
		endcase
	end

	// memory port and array controls
	always_comb begin
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		mem_addr = {req_tag, req_idx, word_cnt, {BYTE_OFF_W{1'b0}}};
		mem_store = rdata;
		set_idx = req_idx;
		way = hit_way;
		word_off = req_off;
		data_we = 1'b0;
		data_wdata = dmem_store;
		tag_we = 1'b0;
		valid_in = 1'b1;
		dirty_in = 1'b0;
		tag_in = req_tag;
		lru_we = 1'b0;
		lru_in = ~hit_way;
		case (state)
			IDLE: begin
				// a write hit marks the block dirty
				data_we = dhit && dmem_wen;
				tag_we = dhit && dmem_wen;
				dirty_in = 1'b1;
				lru_we = dhit;
			end
			WRITE_BACK: begin
				way = victim_way;
				word_off = word_cnt;
				mem_wen = 1'b1;
				mem_addr = {victim_tag, req_idx, word_cnt, {BYTE_OFF_W{1'b0}}};
			end
			ALLOCATE: begin
				way = victim_way;
				word_off = word_cnt;
				mem_ren = 1'b1;
				data_we = !mem_wait;
				data_wdata = mem_load;
				// tag goes valid with the last word
				tag_we = !mem_wait && word_last;
			end
			FLUSH: begin
				set_idx = fl_set;
				way = victim_way;
				word_off = fl_word;
				mem_wen = entry_dirty;
				mem_addr = {victim_tag, fl_set, fl_word, {BYTE_OFF_W{1'b0}}};
				tag_we = entry_end;
				valid_in = 1'b0;
				tag_in = victim_tag;
				// point the victim at the other way for the next pass
				lru_we = entry_end;
				lru_in = ~victim_way;
			end
			FLUSH_COUNT: begin
				mem_wen = 1'b1;
				mem_addr = HIT_CNT_ADDR;
				mem_store = hit_count;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/dcache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array import dcache_pkg::*; #(
	parameter int SETS = 8,
	localparam int IDX_W = $clog2(SETS)
) (
	input logic CLK,
	input logic [IDX_W-1:0] set_idx,
	input logic way,
	input logic [BLK_OFF_W-1:0] word_off,
	input logic we,
	input word_t wdata,
	output word_t rdata
);

	word_t mem [SETS][WAYS][WORDS_PER_BLK];

	// read straight from the indexed word
	assign rdata = mem[set_idx][way][word_off];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[set_idx][way][word_off] <= wdata;
		end
	end

endmodule

`default_nettype wire

/* verilog/dcache_hit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_hit_counter import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic count_en,
	output word_t hit_count
);

	// one per request served without a memory transfer
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			hit_count <= '0;
		end else if (count_en) begin
			hit_count <= hit_count + 32'd1;
		end
	end

endmodule

`default_nettype wire

/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// data word and byte address
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// block geometry, two ways since the LRU state is a single bit
	localparam int WAYS = 2;
	localparam int WORDS_PER_BLK = 2;
	localparam int BLK_OFF_W = 1;
	localparam int BYTE_OFF_W = 2;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		WRITE_BACK,
		ALLOCATE,
		FLUSH,
		FLUSH_COUNT,
		DONE
	} dcache_state_t;

endpackage

`default_nettype wire

/* verilog/dcache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array import dcache_pkg::*; #(
	parameter int SETS = 8,
	localparam int IDX_W = $clog2(SETS),
	localparam int TAG_W = 32 - IDX_W - BLK_OFF_W - BYTE_OFF_W
) (
	input logic CLK,
	input logic nRST,
	input addr_t lookup_addr,
	input logic [IDX_W-1:0] set_idx,
	input logic way,
	input logic tag_we,
	input logic valid_in,
	input logic dirty_in,
	input logic [TAG_W-1:0] tag_in,
	input logic lru_we,
	input logic lru_in,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic [TAG_W-1:0] victim_tag,
	output logic victim_dirty,
	output logic entry_dirty
);

	localparam int IDX_LSB = BLK_OFF_W + BYTE_OFF_W;

	logic [TAG_W-1:0] tags [SETS][WAYS];
	logic [WAYS-1:0] valid [SETS];
	logic [WAYS-1:0] dirty [SETS];
	// lru bit names the way to evict next
	logic [SETS-1:0] lru;

	logic [IDX_W-1:0] lk_idx;
	logic [TAG_W-1:0] lk_tag;
	logic [WAYS-1:0] match;

	assign lk_idx = lookup_addr[IDX_LSB +: IDX_W];
	assign lk_tag = lookup_addr[31 -: TAG_W];

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			match[w] = valid[lk_idx][w] && (tags[lk_idx][w] == lk_tag);
		end
	end

	assign hit = |match;
	assign hit_way = match[1];
	assign victim_way = lru[lk_idx];
	assign victim_tag = tags[lk_idx][victim_way];
	assign victim_dirty = dirty[lk_idx][victim_way];
	// selected entry, walked by the flush
	assign entry_dirty = dirty[set_idx][way];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
			for (int s = 0; s < SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				for (int w = 0; w < WAYS; w++) begin
					tags[s][w] <= '0;
				end
			end
		end else begin
			if (tag_we) begin
				valid[set_idx][way] <= valid_in;
				dirty[set_idx][way] <= dirty_in;
				tags[set_idx][way] <= tag_in;
			end
			if (lru_we) begin
				lru[set_idx] <= lru_in;
			end
		end
	end

endmodule

`default_nettype wire
